// File: filelist.f
src/noc_pkg.sv
src/noc_flit_fifo.sv
src/noc_route_select.sv
src/noc_wormhole_arbiter.sv
src/noc_router.sv
tb/noc_router_properties.sv
tb/tb_noc_router.sv

// File: Bender.yml
package:
  name: noc_router

sources:
  - src/noc_pkg.sv
  - src/noc_flit_fifo.sv
  - src/noc_route_select.sv
  - src/noc_wormhole_arbiter.sv
  - src/noc_router.sv
  - target: test
    files:
      - tb/noc_router_properties.sv
      - tb/tb_noc_router.sv

// File: tb/tb_noc_router.sv
// ##########################################################################
// NoC router testbench
// Directed tests for XY routing, wormhole locking, round-robin grants,
// back-pressure and parallel crossbar paths
// ##########################################################################

`default_nettype none

module tb_noc_router
  import noc_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NodeX         = 1;
  localparam int unsigned NodeY         = 1;
  localparam int unsigned InFifoDepth   = 4;
  localparam int unsigned ResetCycles   = 5;
  // Well above the total length of all tests
  localparam int unsigned TimeoutCycles = 2000;

  logic                 clk_i;
  logic                 rst_n_i;
  logic  [NumPorts-1:0] valid_i;
  logic  [NumPorts-1:0] ready_o;
  flit_t [NumPorts-1:0] data_i;
  logic  [NumPorts-1:0] valid_o;
  logic  [NumPorts-1:0] ready_i;
  flit_t [NumPorts-1:0] data_o;
  int unsigned          cycle_cnt;
  int                   seed;

  noc_router #(
    .NodeX       ( NodeX       ),
    .NodeY       ( NodeY       ),
    .InFifoDepth ( InFifoDepth )
  ) dut_i (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .valid_i ( valid_i ),
    .ready_o ( ready_o ),
    .data_i  ( data_i  ),
    .valid_o ( valid_o ),
    .ready_i ( ready_i ),
    .data_o  ( data_o  )
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      fail_run($sformatf("timeout after %0d cycles, the DUT stopped responding", cycle_cnt));
    end else if (dut_i.i_properties.fail_cnt != 0) begin
      fail_run("a handshake assertion on the router outputs failed");
    end
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    if (got !== exp) begin
      fail_run({
        $sformatf("mismatch %s: got last=%h dst_x=%h dst_y=%h payload=%h", name,
                  got.last, got.dst_x, got.dst_y, got.payload),
        $sformatf(", exp last=%h dst_x=%h dst_y=%h payload=%h",
                  exp.last, exp.dst_x, exp.dst_y, exp.payload)});
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  function automatic flit_t new_flit(input logic last, input int unsigned x, input int unsigned y);
    flit_t f;
    f.last    = last;
    f.dst_x   = CoordWidth'(x);
    f.dst_y   = CoordWidth'(y);
    f.payload = PayloadWidth'($random(seed));
    return f;
  endfunction

  // Inputs change 1 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic apply_reset();
    rst_n_i = 1'b0;
    valid_i = '0;
    ready_i = '1;
    repeat (ResetCycles) step_cycle();
    rst_n_i = 1'b1;
    @(negedge clk_i);
    for (int p = 0; p < NumPorts; p++) begin
      check_bit($sformatf("ready_o[%0d]", p), ready_o[p], 1'b1);
      check_bit($sformatf("valid_o[%0d]", p), valid_o[p], 1'b0);
    end
    step_cycle();
  endtask

  task automatic send_flit(input port_e port, input flit_t f);
    logic accepted;
    valid_i[port] = 1'b1;
    data_i[port]  = f;
    do begin
      @(negedge clk_i);
      accepted = ready_o[port];
      step_cycle();
    end while (!accepted);
    valid_i[port] = 1'b0;
  endtask

  task automatic send_packet(input port_e port, input flit_t pkt[$]);
    foreach (pkt[i]) begin
      send_flit(port, pkt[i]);
    end
  endtask

  // Waits up to max_wait cycles for a transfer on one output
  task automatic expect_flit(input port_e port, input flit_t exp, input int max_wait);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen) begin
      @(negedge clk_i);
      seen = valid_o[port] & ready_i[port];
      waited++;
      if (seen) begin
        check_flit($sformatf("data_o[%s]", port.name()), data_o[port], exp);
      end else if (waited >= max_wait) begin
        fail_run($sformatf("no flit on output %s within %0d cycles", port.name(), max_wait));
      end
      step_cycle();
    end
  endtask

  task automatic xy_routing_test();
    port_e       src [6] = '{Local, Local, Local, Local, North, South};
    port_e       out [6] = '{East, West, North, South, Local, East};
    int unsigned dx  [6] = '{2, 0, 1, 1, 1, 2};
    int unsigned dy  [6] = '{1, 1, 2, 0, 1, 3};
    flit_t       f;
    apply_reset();
    for (int i = 0; i < 6; i++) begin
      f = new_flit(1'b1, dx[i], dy[i]);
      send_flit(src[i], f);
      // Only the routed output is active in the next cycle
      @(negedge clk_i);
      for (int p = 0; p < NumPorts; p++) begin
        check_bit($sformatf("valid_o[%0d]", p), valid_o[p], p == int'(out[i]));
      end
      check_flit($sformatf("data_o[%s]", out[i].name()), data_o[out[i]], f);
      step_cycle();
    end
  endtask

  task automatic wormhole_lock_test();
    flit_t pkt_w[$];
    flit_t pkt_n[$];
    flit_t order[$];
    apply_reset();
    for (int i = 0; i < 4; i++) begin
      // Body dst fields point elsewhere and must be ignored
      pkt_w.push_back(new_flit(i == 3, (i == 0) ? 1 : 0, (i == 0) ? 1 : 3));
      pkt_n.push_back(new_flit(i == 3, (i == 0) ? 1 : 3, (i == 0) ? 1 : 0));
    end
    // Pointer starts at input 0, so North wins the first grant
    order = {pkt_n, pkt_w};
    fork
      send_packet(West, pkt_w);
      send_packet(North, pkt_n);
      begin
        step_cycle();
        foreach (order[i]) expect_flit(Local, order[i], 1);
      end
    join
  endtask

  task automatic round_robin_test();
    flit_t q [4][$];
    apply_reset();
    for (int p = 0; p < 4; p++) begin
      q[p].push_back(new_flit(1'b1, 1, 1));
      q[p].push_back(new_flit(1'b1, 1, 1));
    end
    fork
      send_packet(North, q[0]);
      send_packet(East, q[1]);
      send_packet(South, q[2]);
      send_packet(West, q[3]);
      begin
        step_cycle();
        // Pointer moves past each winner, wrapping from Local to North
        for (int r = 0; r < 2; r++) begin
          for (int p = 0; p < 4; p++) begin
            expect_flit(Local, q[p][r], 1);
          end
        end
      end
    join
  endtask

  task automatic back_pressure_test();
    flit_t       pkt[$];
    int unsigned start_cycle;
    apply_reset();
    for (int i = 0; i < 5; i++) begin
      pkt.push_back(new_flit(i == 4, 2, 1));
    end
    ready_i[East] = 1'b0;
    start_cycle   = cycle_cnt;
    for (int i = 0; i < InFifoDepth; i++) begin
      send_flit(Local, pkt[i]);
    end
    if (cycle_cnt - start_cycle != InFifoDepth) begin
      fail_run("Local input stalled before its FIFO was full");
    end
    repeat (3) begin
      @(negedge clk_i);
      check_bit("ready_o[Local]", ready_o[Local], 1'b0);
      check_bit("valid_o[East]", valid_o[East], 1'b1);
      check_flit("data_o[East]", data_o[East], pkt[0]);
      step_cycle();
    end
    ready_i[East] = 1'b1;
    fork
      send_flit(Local, pkt[4]);
      foreach (pkt[i]) expect_flit(East, pkt[i], 1);
    join
  endtask

  task automatic parallel_paths_test();
    flit_t pkt_e[$];
    flit_t pkt_s[$];
    apply_reset();
    for (int i = 0; i < 4; i++) begin
      pkt_e.push_back(new_flit(i == 3, 2, 1));
      pkt_s.push_back(new_flit(i == 3, 1, 0));
    end
    fork
      send_packet(West, pkt_e);
      send_packet(North, pkt_s);
      begin
        step_cycle();
        for (int i = 0; i < 4; i++) begin
          @(negedge clk_i);
          check_bit("valid_o[East]", valid_o[East], 1'b1);
          check_bit("valid_o[South]", valid_o[South], 1'b1);
          check_flit("data_o[East]", data_o[East], pkt_e[i]);
          check_flit("data_o[South]", data_o[South], pkt_s[i]);
          step_cycle();
        end
      end
    join
  endtask

  initial begin
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    valid_i   = '0;
    ready_i   = '1;
    data_i    = '0;
    cycle_cnt = 0;
    seed      = 32'hd5dc;
    xy_routing_test();
    wormhole_lock_test();
    round_robin_test();
    back_pressure_test();
    parallel_paths_test();
    if (dut_i.i_properties.fail_cnt != 0) begin
      fail_run($sformatf("%0d handshake assertion failures", dut_i.i_properties.fail_cnt));
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tb/noc_router_properties.sv
// ##########################################################################
// Router handshake properties
// Output flits hold under back-pressure and outputs stay quiet in reset
// ##########################################################################

`default_nettype none

module noc_router_properties
  import noc_pkg::*;
(
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic  [NumPorts-1:0] valid_o,
  input logic  [NumPorts-1:0] ready_i,
  input flit_t [NumPorts-1:0] data_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    // A waiting flit stays on the output until it is taken
    hold_valid: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      valid_o[p] && !ready_i[p] |=> valid_o[p]
    ) else begin
      $error("valid_o[%0d] dropped while ready_i was low", p);
      fail_cnt++;
    end

    hold_data: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      valid_o[p] && !ready_i[p] |=> $stable(data_o[p])
    ) else begin
      $error("data_o[%0d] changed while ready_i was low", p);
      fail_cnt++;
    end
  end

  quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> valid_o == '0)
    else begin
      $error("valid_o active during reset");
      fail_cnt++;
    end

endmodule

bind noc_router noc_router_properties i_properties (
  .clk_i   ( clk_i   ),
  .rst_n_i ( rst_n_i ),
  .valid_o ( valid_o ),
  .ready_i ( ready_i ),
  .data_o  ( data_o  )
);

`default_nettype wire

// File: src/noc_router.sv
// ##########################################################################
// Five-port mesh router
// Input FIFOs with XY route selection, a masked crossbar and one
// wormhole arbiter per output
// ##########################################################################

`default_nettype none

module noc_router
  import noc_pkg::*;
#(
  parameter int unsigned NodeX       = 0,
  parameter int unsigned NodeY       = 0,
  parameter int unsigned InFifoDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Ready may be raised before valid
  input  logic  [NumPorts-1:0] valid_i,
  output logic  [NumPorts-1:0] ready_o,
  input  flit_t [NumPorts-1:0] data_i,

  output logic  [NumPorts-1:0] valid_o,
  input  logic  [NumPorts-1:0] ready_i,
  output flit_t [NumPorts-1:0] data_o
);

  flit_t  [NumPorts-1:0]                in_data;
  logic   [NumPorts-1:0]                in_valid;
  logic   [NumPorts-1:0]                in_ready;
  route_t [NumPorts-1:0]                route_mask;

  // Indexed [output][input]
  logic   [NumPorts-1:0][NumPorts-1:0] out_req;
  logic   [NumPorts-1:0][NumPorts-1:0] out_ready;

  // Indexed [input][output]
  logic   [NumPorts-1:0][NumPorts-1:0] in_all_ready;

  // Input stages
  for (genvar in_port = 0; in_port < NumPorts; in_port++) begin : gen_input

    noc_flit_fifo #(
      .Depth ( InFifoDepth )
    ) i_flit_fifo (
      .clk_i   ( clk_i             ),
      .rst_n_i ( rst_n_i           ),
      .valid_i ( valid_i [in_port] ),
      .ready_o ( ready_o [in_port] ),
      .data_i  ( data_i  [in_port] ),
      .valid_o ( in_valid[in_port] ),
      .ready_i ( in_ready[in_port] ),
      .data_o  ( in_data [in_port] )
    );

    noc_route_select #(
      .NodeX ( NodeX ),
      .NodeY ( NodeY )
    ) i_route_select (
      .clk_i   ( clk_i               ),
      .rst_n_i ( rst_n_i             ),
      .valid_i ( in_valid  [in_port] ),
      .ready_i ( in_ready  [in_port] ),
      .flit_i  ( in_data   [in_port] ),
      .route_o ( route_mask[in_port] )
    );

    // Ready comes only from the output this input is routed to
    assign in_ready[in_port] = |(in_all_ready[in_port] & route_mask[in_port]);
  end

  // Crossbar request masking
  for (genvar in_port = 0; in_port < NumPorts; in_port++) begin : gen_xbar_in
    for (genvar out_port = 0; out_port < NumPorts; out_port++) begin : gen_xbar_out
      if (in_port == out_port) begin : gen_no_loopback
        // A flit never turns back through the port it came in on
        assign out_req[out_port][in_port] = 1'b0;
      end else begin : gen_req
        assign out_req[out_port][in_port] =
          in_valid[in_port] & route_mask[in_port][out_port];
      end
      // Arbiter never grants an input without a request
      assign in_all_ready[in_port][out_port] = out_ready[out_port][in_port];
    end
  end

  // Output arbiters
  for (genvar out_port = 0; out_port < NumPorts; out_port++) begin : gen_output

    noc_wormhole_arbiter i_wormhole_arbiter (
      .clk_i   ( clk_i               ),
      .rst_n_i ( rst_n_i             ),
      .valid_i ( out_req  [out_port] ),
      .ready_o ( out_ready[out_port] ),
      .data_i  ( in_data             ),
      .valid_o ( valid_o  [out_port] ),
      .ready_i ( ready_i  [out_port] ),
      .data_o  ( data_o   [out_port] )
    );
  end

endmodule

`default_nettype wire

// File: src/noc_wormhole_arbiter.sv
// ##########################################################################
// Wormhole output arbiter
// Round-robin choice among requesting inputs, locked to the winner
// until the tail flit of its packet has left
// ##########################################################################

`default_nettype none

module noc_wormhole_arbiter
  import noc_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  logic  [NumPorts-1:0] valid_i,
  output logic  [NumPorts-1:0] ready_o,
  input  flit_t [NumPorts-1:0] data_i,

  output logic                 valid_o,
  input  logic                 ready_i,
  output flit_t                data_o
);

  localparam int unsigned IdxWidth = $clog2(NumPorts);

  typedef enum logic {
    Idle,
    Locked
  } state_e;

  state_e              state_q;
  logic [IdxWidth-1:0] lock_idx_q;
  logic [IdxWidth-1:0] rr_ptr_q;
  logic [IdxWidth-1:0] gnt_idx;
  logic [IdxWidth-1:0] next_ptr;
  logic                gnt_found;
  logic                xfer;

  // Grant selection
  always_comb begin
    gnt_found = 1'b0;
    gnt_idx   = lock_idx_q;
    if (state_q == Locked) begin
      // Locked input may pause mid-packet and the lock still holds
      gnt_found = valid_i[lock_idx_q];
    end else begin
      for (int i = 0; i < NumPorts; i++) begin
        if (!gnt_found && valid_i[(int'(rr_ptr_q) + i) % NumPorts]) begin
          gnt_found = 1'b1;
          gnt_idx   = IdxWidth'((int'(rr_ptr_q) + i) % NumPorts);
        end
      end
    end
  end

  always_comb begin
    ready_o = '0;
    if (gnt_found) begin
      ready_o[gnt_idx] = ready_i;
    end
  end

  assign valid_o  = gnt_found;
  assign data_o   = data_i[gnt_idx];
  assign xfer     = valid_o & ready_i;
  assign next_ptr = (gnt_idx == IdxWidth'(NumPorts - 1)) ? '0 : gnt_idx + 1'b1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= Idle;
      lock_idx_q <= '0;
      rr_ptr_q   <= '0;
    end else if (xfer) begin
      if (data_o.last) begin
        // After the tail the next search starts behind the winner
        state_q  <= Idle;
        rr_ptr_q <= next_ptr;
      end else begin
        state_q    <= Locked;
        lock_idx_q <= gnt_idx;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/noc_route_select.sv
// ##########################################################################
// XY route selector
// Resolves X first, then Y, from the head flit and holds that route
// until the tail flit has been transferred
// ##########################################################################

`default_nettype none

module noc_route_select
  import noc_pkg::*;
#(
  parameter int unsigned NodeX = 0,
  parameter int unsigned NodeY = 0
) (
  input  logic   clk_i,
  input  logic   rst_n_i,

  input  logic   valid_i,
  input  logic   ready_i,
  input  flit_t  flit_i,

  output route_t route_o
);

  logic   open_q;
  route_t route_q;
  route_t xy_route;
  logic   xfer;

  // Dimension-ordered decision on the current flit
  always_comb begin
    xy_route = '0;
    if (flit_i.dst_x > CoordWidth'(NodeX)) begin
      xy_route[East] = 1'b1;
    end else if (flit_i.dst_x < CoordWidth'(NodeX)) begin
      xy_route[West] = 1'b1;
    end else if (flit_i.dst_y > CoordWidth'(NodeY)) begin
      xy_route[North] = 1'b1;
    end else if (flit_i.dst_y < CoordWidth'(NodeY)) begin
      xy_route[South] = 1'b1;
    end else begin
      xy_route[Local] = 1'b1;
    end
  end

  assign xfer = valid_i & ready_i;

  // Body and tail flits ignore their own dst fields
  assign route_o = open_q ? route_q : xy_route;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      open_q  <= 1'b0;
      route_q <= '0;
    end else if (xfer) begin
      if (flit_i.last) begin
        open_q  <= 1'b0;
        route_q <= '0;
      end else if (!open_q) begin
        open_q  <= 1'b1;
        route_q <= xy_route;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/noc_flit_fifo.sv
// ##########################################################################
// Input flit FIFO
// Circular buffer with valid/ready on both sides, head entry read
// straight from the storage registers
// ##########################################################################

`default_nettype none

module noc_flit_fifo
  import noc_pkg::*;
#(
  parameter int unsigned Depth = 4
) (
  input  logic  clk_i,
  input  logic  rst_n_i,

  input  logic  valid_i,
  output logic  ready_o,
  input  flit_t data_i,

  output logic  valid_o,
  input  logic  ready_i,
  output flit_t data_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  flit_t               mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push, pop, full;

  assign full    = (count_q == CntWidth'(Depth));
  assign valid_o = (count_q != '0);
  assign pop     = valid_o & ready_i;
  // A full buffer still takes a flit when the head leaves in the same cycle
  assign ready_o = ~full | pop;
  assign push    = valid_i & ready_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: src/noc_pkg.sv
// ##########################################################################
// NoC router package
// Port directions, mesh coordinates and the flit format shared by the
// input buffers, route selectors and output arbiters
// ##########################################################################

`default_nettype none

package noc_pkg;

  // Router ports whose values double as port indices
  localparam int unsigned NumPorts = 5;

  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Local = 3'd4
  } port_e;

  // 2-bit coordinates give a 4 by 4 mesh
  localparam int unsigned CoordWidth   = 2;
  localparam int unsigned PayloadWidth = 16;

  // Only the head flit has to carry a meaningful destination
  typedef struct packed {
    logic                    last;
    logic [CoordWidth-1:0]   dst_x;
    logic [CoordWidth-1:0]   dst_y;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

  // One-hot output selection
  typedef logic [NumPorts-1:0] route_t;

endpackage

`default_nettype wire
